//--- EvtBuild.f
+incdir+testbench
design/EvtBuildPkg.sv
design/FragBuf.sv
design/EventSequencer.sv
design/EvtBuild.sv
testbench/EvtBuildTb.sv

//--- run.sh
#!/bin/sh
# Builds the event builder testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module EvtBuildTb -f EvtBuild.f -o EvtBuildSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/EvtBuildSim > "$LOG" 2>&1
STATUS=$?
cat "$LOG"
if [ $STATUS -ne 0 ]; then
	echo "Simulation exited with status $STATUS"
	exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
	echo "Simulation reported failures, see $LOG"
	exit 1
fi
echo "Simulation passed"
exit 0

//--- testbench/EvtBuildTbTable.svh
/*
 Event scenarios for the event builder testbench
 One row per event with the enabled and written channels, the header
 inputs, the fragment length per channel and the Ethernet hold time
*/
`ifndef EVT_BUILD_TB_TABLE_SVH
`define EVT_BUILD_TB_TABLE_SVH

typedef struct packed {
	logic [3:0] Mask;        // Channels enabled in the event
	logic [3:0] WrMask;      // Channels that get new fragments before it
	logic TagOut;
	logic [11:0] DeltaT;
	logic [35:0] TimeTag;
	logic [3:0][4:0] Len;    // Fragment length per channel, channel 3 leftmost
	logic [1:0] Dup;         // Fragments written to each channel in WrMask
	logic [3:0] HoldCyc;     // Extra EthHold cycles once every fragment is in
} RowT;

localparam int NumRows = 9;

// Channel 0 holds two maximum fragments in rows 3 and 6, masked in between
localparam RowT Rows [NumRows] = '{
	// Mask  WrMask TagOut DeltaT TimeTag  Len ch3..ch0  Dup  HoldCyc
	'{4'hF, 4'hF, 1'b1, 12'h123, 36'h9ABCD1234, {5'd7, 5'd2, 5'd5, 5'd3}, 2'd1, 4'd2},
	'{4'hF, 4'hF, 1'b0, 12'h7FF, 36'h000000000, {5'd2, 5'd1, 5'd1, 5'd1}, 2'd1, 4'd0},
	'{4'h5, 4'h5, 1'b1, 12'hABC, 36'h123456789, {5'd0, 5'd6, 5'd0, 5'd4}, 2'd1, 4'd3},
	'{4'h1, 4'h1, 1'b0, 12'h001, 36'h000000000, {5'd0, 5'd0, 5'd0, 5'd31}, 2'd2, 4'd4},
	'{4'hE, 4'hE, 1'b1, 12'hFFF, 36'hF0F0F0F0F, {5'd12, 5'd1, 5'd8, 5'd0}, 2'd1, 4'd1},
	'{4'h6, 4'h7, 1'b0, 12'h555, 36'h000000000, {5'd0, 5'd3, 5'd2, 5'd31}, 2'd1, 4'd0},
	'{4'hF, 4'hE, 1'b1, 12'h2A0, 36'h000000001, {5'd9, 5'd4, 5'd10, 5'd0}, 2'd1, 4'd2},
	'{4'hF, 4'hE, 1'b0, 12'h010, 36'h000000000, {5'd1, 5'd1, 5'd1, 5'd0}, 2'd1, 4'd1},
	'{4'h0, 4'h0, 1'b0, 12'h3C3, 36'h000000000, {5'd0, 5'd0, 5'd0, 5'd0}, 2'd1, 4'd1}
};

`endif

//--- testbench/EvtBuildTb.sv
/*
 Event builder testbench
 Loads fragments into the channel buffers, holds the Ethernet side off,
 then compares every strobed word with the event expected from the table
*/
module EvtBuildTb
	import EvtBuildPkg::*;
();

	localparam int NumChan = 4;
	localparam int FragDepth = 64;
	localparam int RstCycles = 5;

	`include "EvtBuildTbTable.svh"

	logic Clock = 1'b0;
	logic rst;
	WordT [NumChan-1:0] WordIn;
	logic [NumChan-1:0] WordValid, WordLast, Mask, BufRdy;
	logic TagOut, EthHold, Strobe, EvStart, HoldSnd;
	WordT DeltaT, DataOut;
	logic [TagW-1:0] TimeTag;
	EvtNumT NEvent;

	WordT ChanWords [NumChan][$];   // Words held in each buffer, oldest first
	int ChanLens [NumChan][$];      // Lengths of the fragments held
	WordT ExpQ [$];                 // Words of the event in progress
	EvtNumT ExpEvents;
	int Checks = 0;
	int Errors = 0;
	int Cycles = 0;
	int TimeLimit;

	EvtBuild #(.NumChan(NumChan), .FragDepth(FragDepth)) uut (.*);

	always #20 Clock = ~Clock;

	// Stops a run in which an event never starts or never ends
	always @(posedge Clock) begin
		Cycles <= Cycles + 1;
		if (Cycles >= TimeLimit) begin
			$display("Timeout after %0d cycles, the expected events did not complete", Cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic CheckValue(input string Name, input logic [63:0] Got, input logic [63:0] Exp);
		Checks++;
		if (Got !== Exp) begin
			Errors++;
			$display("CHECK FAILED %s: got %0h, expected %0h", Name, Got, Exp);
		end
	endtask

	// Ready is one per channel holding a fragment, hold needs room for a full fragment
	task automatic CheckLevels(input logic [NumChan-1:0] En);
		logic [NumChan-1:0] Rdy;
		logic Hold;
		Rdy = '0;
		Hold = 1'b0;
		for (int c = 0; c < NumChan; c++) begin
			Rdy[c] = (ChanLens[c].size() != 0);
			if (En[c] && (FragDepth - ChanWords[c].size()) < MaxFragLen) Hold = 1'b1;
		end
		CheckValue("BufRdy", 64'(BufRdy), 64'(Rdy));
		CheckValue("HoldSnd", 64'(HoldSnd), 64'(Hold));
	endtask

	// All written channels are loaded side by side, one word per cycle each
	task automatic LoadFragments(input int r);
		int MaxLen;
		int Len;
		WordT Word;
		MaxLen = 0;
		for (int c = 0; c < NumChan; c++) begin
			if (Rows[r].WrMask[c] && int'(Rows[r].Len[c]) > MaxLen) MaxLen = int'(Rows[r].Len[c]);
		end
		for (int d = 0; d < int'(Rows[r].Dup); d++) begin
			for (int k = 0; k < MaxLen; k++) begin
				@(posedge Clock);
				for (int c = 0; c < NumChan; c++) begin
					Len = Rows[r].WrMask[c] ? int'(Rows[r].Len[c]) : 0;
					WordValid[c] <= (k < Len);
					WordLast[c] <= (k == Len - 1);   // Only ever true together with valid
					if (k < Len) begin
						Word = WordT'($urandom());
						WordIn[c] <= Word;
						ChanWords[c].push_back(Word);
						if (k == Len - 1) ChanLens[c].push_back(Len);
					end
				end
			end
		end
		@(posedge Clock);
		WordValid <= '0;
		WordLast <= '0;
	endtask

	// Event layout taken word by word from the stream rules
	task automatic BuildExpected(input int r);
		int Len;
		ExpQ.delete();
		ExpQ.push_back(MarkerA);
		ExpQ.push_back(MarkerB);
		if (Rows[r].TagOut) begin
			ExpQ.push_back(Rows[r].TimeTag[35:24]);   // Most significant word first
			ExpQ.push_back(Rows[r].TimeTag[23:12]);
			ExpQ.push_back(Rows[r].TimeTag[11:0]);
		end
		ExpQ.push_back(Rows[r].DeltaT);
		ExpQ.push_back({EvtNumFlag, ExpEvents[21:12]});
		ExpQ.push_back(ExpEvents[11:0]);
		for (int c = 0; c < NumChan; c++) begin
			Len = 0;   // A masked channel sends its header and keeps its data
			if (Rows[r].Mask[c]) Len = ChanLens[c].pop_front();
			ExpQ.push_back({4'(c), ExpEvents[2:0], LenT'(Len)});
			for (int k = 0; k < Len; k++) ExpQ.push_back(ChanWords[c].pop_front());
		end
		if (ExpQ.size() % 2 != 0) ExpQ.push_back('0);
	endtask

	task automatic RunEvent(input int r);
		@(posedge Clock);
		Mask <= Rows[r].Mask;
		TagOut <= Rows[r].TagOut;
		DeltaT <= Rows[r].DeltaT;
		TimeTag <= Rows[r].TimeTag;
		LoadFragments(r);
		@(negedge Clock);
		CheckLevels(Rows[r].Mask);
		repeat (int'(Rows[r].HoldCyc)) begin
			@(negedge Clock);   // Start condition is met apart from the hold
			CheckValue("EvStart", 64'(EvStart), 64'(0));
			CheckValue("Strobe", 64'(Strobe), 64'(0));
		end
		BuildExpected(r);
		@(posedge Clock);
		EthHold <= 1'b0;
		@(negedge Clock);
		while (!EvStart) begin
			CheckValue("Strobe", 64'(Strobe), 64'(0));
			@(negedge Clock);
		end
		CheckValue("NEvent", 64'(NEvent), 64'(ExpEvents));
		@(posedge Clock);
		EthHold <= 1'b1;   // Keeps leftover fragments from starting another event
		TagOut <= !Rows[r].TagOut;   // The event keeps the header inputs seen at EvStart
		DeltaT <= ~Rows[r].DeltaT;
		TimeTag <= ~Rows[r].TimeTag;
		foreach (ExpQ[i]) begin
			@(negedge Clock);
			CheckValue("Strobe", 64'(Strobe), 64'(1));
			CheckValue("EvStart", 64'(EvStart), 64'(0));
			CheckValue("DataOut", 64'(DataOut), 64'(ExpQ[i]));
		end
		@(negedge Clock);
		ExpEvents = ExpEvents + 1;
		CheckValue("Strobe", 64'(Strobe), 64'(0));
		CheckValue("NEvent", 64'(NEvent), 64'(ExpEvents));
		CheckLevels(Rows[r].Mask);
	endtask

	initial begin
		void'($urandom(65));
		TimeLimit = RstCycles;
		for (int r = 0; r < NumRows; r++) begin
			TimeLimit += 50;
			for (int c = 0; c < NumChan; c++) begin
				if (Rows[r].WrMask[c]) TimeLimit += int'(Rows[r].Len[c]) * int'(Rows[r].Dup);
			end
		end
		rst <= 1'b1;
		WordIn <= '0;
		WordValid <= '0;
		WordLast <= '0;
		Mask <= '1;   // HoldSnd then follows every buffer
		TagOut <= 1'b0;
		DeltaT <= '0;
		TimeTag <= '0;
		EthHold <= 1'b1;
		ExpEvents = '0;
		repeat (RstCycles) @(posedge Clock);
		rst <= 1'b0;
		@(negedge Clock);
		CheckValue("Strobe", 64'(Strobe), 64'(0));
		CheckValue("EvStart", 64'(EvStart), 64'(0));
		CheckValue("HoldSnd", 64'(HoldSnd), 64'(0));
		CheckValue("BufRdy", 64'(BufRdy), 64'(0));
		CheckValue("NEvent", 64'(NEvent), 64'(0));
		for (int r = 0; r < NumRows; r++) RunEvent(r);
		$display("Checks run: %0d, mismatches: %0d", Checks, Errors);
		if (Errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- design/EvtBuild.sv
/*
 Event builder top level
 One fragment buffer per front-end channel feeding a sequencer that
 merges them into a single stream of 12-bit event words
*/
module EvtBuild
	import EvtBuildPkg::*;
#(
	parameter int NumChan = 4,     // Front-end channels
	parameter int FragDepth = 64   // Buffer words per channel
) (
	input  logic Clock,
	input  logic rst,
	input  WordT [NumChan-1:0] WordIn,     // Fragment words per channel
	input  logic [NumChan-1:0] WordValid,
	input  logic [NumChan-1:0] WordLast,   // Marks the final word of a fragment
	input  logic [NumChan-1:0] Mask,       // Channels taking part in events
	input  logic TagOut,                   // Put the time tag in each event
	input  WordT DeltaT,
	input  logic [TagW-1:0] TimeTag,
	input  logic EthHold,                  // Ethernet side holds off new events
	output WordT DataOut,                  // Event stream
	output logic Strobe,                   // DataOut is valid
	output logic EvStart,
	output logic [NumChan-1:0] BufRdy,     // Fragment ready per channel
	output logic HoldSnd,                  // Front ends must stop sending
	output EvtNumT NEvent
);

	logic [NumChan-1:0] Ready;
	logic [NumChan-1:0] NoRoom;
	logic [NumChan-1:0] Pop;
	WordT [NumChan-1:0] HeadWord;
	LenT  [NumChan-1:0] HeadLen;

	for (genvar i = 0; i < NumChan; i++) begin : gChan
		FragBuf #(
			.FragDepth(FragDepth)
		) uBuf (
			.Clock(Clock),
			.rst(rst),
			.WordIn(WordIn[i]),
			.WordValid(WordValid[i]),
			.WordLast(WordLast[i]),
			.Pop(Pop[i]),
			.HeadWord(HeadWord[i]),
			.HeadLen(HeadLen[i]),
			.Ready(Ready[i]),
			.NoRoom(NoRoom[i])
		);
	end

	EventSequencer #(
		.NumChan(NumChan)
	) uSeq (
		.Clock(Clock),
		.rst(rst),
		.Ready(Ready),
		.HeadWord(HeadWord),
		.HeadLen(HeadLen),
		.Mask(Mask),
		.TagOut(TagOut),
		.DeltaT(DeltaT),
		.TimeTag(TimeTag),
		.EthHold(EthHold),
		.Pop(Pop),
		.DataOut(DataOut),
		.Strobe(Strobe),
		.EvStart(EvStart),
		.NEvent(NEvent)
	);

	assign BufRdy = Ready;
	assign HoldSnd = |(NoRoom & Mask);   // A disabled channel never holds the front ends

endmodule

//--- design/EventSequencer.sv
/*
 Event sequencer
 Waits until every enabled channel holds a fragment, then sends one event
 of 12-bit words: markers, optional time tag, delta-T, event number, and
 a header plus data for each channel, padded to an even word count
*/
module EventSequencer
	import EvtBuildPkg::*;
#(
	parameter int NumChan = 4
) (
	input  logic Clock,
	input  logic rst,
	input  logic [NumChan-1:0] Ready,     // Fragment available per channel
	input  WordT [NumChan-1:0] HeadWord,  // Oldest word per channel
	input  LenT  [NumChan-1:0] HeadLen,   // Oldest fragment length per channel
	input  logic [NumChan-1:0] Mask,      // Enabled channels
	input  logic TagOut,                  // Include the time tag words
	input  WordT DeltaT,                  // Time since the previous trigger
	input  logic [TagW-1:0] TimeTag,      // Time since start of run
	input  logic EthHold,                 // Ethernet side cannot take an event
	output logic [NumChan-1:0] Pop,       // Consume one word from a channel
	output WordT DataOut,                 // Output word, valid with Strobe
	output logic Strobe,
	output logic EvStart,                 // One cycle as an event begins
	output EvtNumT NEvent                 // Completed event count
);

	localparam int ChanW = (NumChan > 1) ? $clog2(NumChan) : 1;

	// Each state names the word sitting in the output register during it
	typedef enum logic [13:0] {
		Wait     = 14'h0001,
		Start    = 14'h0002,
		MarkA    = 14'h0004,
		MarkB    = 14'h0008,
		Tag1     = 14'h0010,
		Tag2     = 14'h0020,
		Tag3     = 14'h0040,
		DelT     = 14'h0080,
		Num1     = 14'h0100,
		Num2     = 14'h0200,
		ChanHdr  = 14'h0400,
		ChanData = 14'h0800,
		Pad      = 14'h1000,
		Done     = 14'h2000
	} StateT;

	StateT State, NextState;
	logic [ChanW-1:0] Chan, NextChan;   // Channel being sent
	LenT WordCnt, NextCnt;   // Data words still to send for Chan
	WordT NextWord;
	logic NextStrobe;
	logic Odd;   // Odd number of words sent so far in this event
	logic [TagW-1:0] TagReg;
	WordT DelTReg;
	logic TagOutReg;
	logic StartOk, LastChan;
	logic [ChanW-1:0] HdrChan;   // Channel whose header goes out next
	LenT HdrLen;
	WordT HdrWord;

	// Masked channels count as ready
	assign StartOk = (&(Ready | ~Mask)) && !EthHold;
	assign LastChan = (Chan == ChanW'(NumChan - 1));

	// After the event number the first header is channel 0, otherwise the next one
	always_comb begin
		if (State == Num2) begin
			HdrChan = '0;
		end else if (LastChan) begin
			HdrChan = Chan;   // Not used, keeps the index in range
		end else begin
			HdrChan = Chan + 1'b1;
		end
	end

	assign HdrLen = Mask[HdrChan] ? HeadLen[HdrChan] : '0;   // Disabled channel reports no data
	assign HdrWord = {4'(HdrChan), NEvent[2:0], HdrLen};

	assign EvStart = (State == Start);

	// Next state, next output word and pops
	always_comb begin
		NextState = State;
		NextChan = Chan;
		NextCnt = WordCnt;
		NextWord = '0;
		NextStrobe = 1'b0;
		Pop = '0;
		case (State)
			Wait: begin
				if (StartOk) NextState = Start;
			end
			Start: begin
				NextState = MarkA;
				NextWord = MarkerA;
				NextStrobe = 1'b1;
			end
			MarkA: begin
				NextState = MarkB;
				NextWord = MarkerB;
				NextStrobe = 1'b1;
			end
			MarkB: begin
				NextStrobe = 1'b1;
				if (TagOutReg) begin
					NextState = Tag1;
					NextWord = TagReg[TagW-1 -: WordW];   // Most significant part first
				end else begin
					NextState = DelT;
					NextWord = DelTReg;
				end
			end
			Tag1: begin
				NextState = Tag2;
				NextWord = TagReg[2*WordW-1 -: WordW];
				NextStrobe = 1'b1;
			end
			Tag2: begin
				NextState = Tag3;
				NextWord = TagReg[WordW-1:0];
				NextStrobe = 1'b1;
			end
			Tag3: begin
				NextState = DelT;
				NextWord = DelTReg;
				NextStrobe = 1'b1;
			end
			DelT: begin
				NextState = Num1;
				NextWord = {EvtNumFlag, NEvent[21:12]};
				NextStrobe = 1'b1;
			end
			Num1: begin
				NextState = Num2;
				NextWord = NEvent[11:0];
				NextStrobe = 1'b1;
			end
			Num2: begin
				NextState = ChanHdr;
				NextChan = HdrChan;
				NextCnt = HdrLen;
				NextWord = HdrWord;
				NextStrobe = 1'b1;
			end
			ChanHdr, ChanData: begin
				if (WordCnt != '0) begin
					// Take the head word and advance that buffer in the same cycle
					NextState = ChanData;
					NextWord = HeadWord[Chan];
					NextCnt = WordCnt - 1'b1;
					NextStrobe = 1'b1;
					Pop[Chan] = 1'b1;
				end else if (!LastChan) begin
					NextState = ChanHdr;
					NextChan = HdrChan;
					NextCnt = HdrLen;
					NextWord = HdrWord;
					NextStrobe = 1'b1;
				end else if (Odd) begin
					NextState = Pad;   // Zero word brings the count to even
					NextStrobe = 1'b1;
				end else begin
					NextState = Done;
				end
			end
			Pad: begin
				NextState = Done;
			end
			Done: begin
				NextState = Wait;
			end
			default: begin
				NextState = Wait;
			end
		endcase
	end

	// State, channel walk and word parity
	always_ff @(posedge Clock) begin
		if (rst) begin
			State <= Wait;
			Chan <= '0;
			WordCnt <= '0;
			Odd <= 1'b0;
			Strobe <= 1'b0;
		end else begin
			State <= NextState;
			Chan <= NextChan;
			WordCnt <= NextCnt;
			Strobe <= NextStrobe;
			if (State == Wait) begin
				Odd <= 1'b0;   // New event starts even
			end else if (NextStrobe) begin
				Odd <= ~Odd;
			end
		end
	end

	always_ff @(posedge Clock) begin
		DataOut <= NextWord;
	end

	// Event inputs are held for the whole event
	always_ff @(posedge Clock) begin
		if (State == Start) begin
			TagReg <= TimeTag;
			DelTReg <= DeltaT;
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			TagOutReg <= 1'b0;
			NEvent <= '0;
		end else begin
			if (State == Start) TagOutReg <= TagOut;
			if (NextState == Done) NEvent <= NEvent + 1'b1;   // Counts right after the last word
		end
	end

endmodule

//--- design/FragBuf.sv
/*
 Per-channel fragment buffer
 Stores incoming words in a circular memory and keeps a queue of the
 lengths of complete fragments. Shows the oldest word and the length
 of the oldest complete fragment to the event sequencer
*/
module FragBuf
	import EvtBuildPkg::*;
#(
	parameter int FragDepth = 64   // Words of storage
) (
	input  logic Clock,
	input  logic rst,
	input  WordT WordIn,      // Incoming fragment word
	input  logic WordValid,   // WordIn holds a word this cycle
	input  logic WordLast,    // Final word of the fragment
	input  logic Pop,         // Consume HeadWord
	output WordT HeadWord,    // Oldest unread word
	output LenT  HeadLen,     // Length of the oldest complete fragment
	output logic Ready,       // At least one complete fragment is stored
	output logic NoRoom       // Not enough space left for a maximum fragment
);

	localparam int AddrW = (FragDepth > 1) ? $clog2(FragDepth) : 1;

	WordT Mem [FragDepth];   // Word storage
	LenT LenMem [FragDepth];   // One entry per complete fragment, never more than words

	logic [AddrW-1:0] WrPtr, RdPtr;
	logic [AddrW:0] Count;   // Words currently held
	logic [AddrW-1:0] LenWr, LenRd;
	logic [AddrW:0] LenCnt;   // Complete fragments currently held
	LenT WrLen;   // Words accepted so far in the fragment being written
	LenT RdCnt;   // Words popped so far from the head fragment
	LenT FragLen;
	logic Full, Wr, Rd, Push, Retire;

	// Pointer advance with wrap, so depths that are not a power of two work
	function automatic logic [AddrW-1:0] NextPtr(input logic [AddrW-1:0] Ptr);
		if (Ptr == AddrW'(FragDepth - 1)) begin
			return '0;
		end
		return Ptr + 1'b1;
	endfunction

	assign Full = (Count == (AddrW+1)'(FragDepth));
	assign Wr = WordValid && !Full;   // Words arriving while full are lost
	assign Rd = Pop && Ready;
	assign FragLen = WrLen + LenT'(Wr);   // Length including the word in flight

	// A fragment whose words were all dropped leaves nothing to queue
	assign Push = WordValid && WordLast && (FragLen != '0);
	assign Retire = Rd && ((RdCnt + 1'b1) == HeadLen);   // Last word of the head fragment

	assign HeadWord = Mem[RdPtr];
	assign HeadLen = LenMem[LenRd];
	assign Ready = (LenCnt != '0);
	assign NoRoom = (FragDepth - int'(Count)) < MaxFragLen;

	// Memory writes
	always_ff @(posedge Clock) begin
		if (Wr) begin
			Mem[WrPtr] <= WordIn;
		end
		if (Push) begin
			LenMem[LenWr] <= FragLen;
		end
	end

	// Word pointers and occupancy
	always_ff @(posedge Clock) begin
		if (rst) begin
			WrPtr <= '0;
			RdPtr <= '0;
			Count <= '0;
		end else begin
			if (Wr) WrPtr <= NextPtr(WrPtr);
			if (Rd) RdPtr <= NextPtr(RdPtr);
			if (Wr && !Rd) begin
				Count <= Count + 1'b1;
			end else if (Rd && !Wr) begin
				Count <= Count - 1'b1;
			end
		end
	end

	// Fragment length counter on the write side
	always_ff @(posedge Clock) begin
		if (rst) begin
			WrLen <= '0;
		end else if (WordValid && WordLast) begin
			WrLen <= '0;   // Restart for the next fragment
		end else if (Wr) begin
			WrLen <= WrLen + 1'b1;
		end
	end

	// Length queue and read-side word counter
	always_ff @(posedge Clock) begin
		if (rst) begin
			LenWr <= '0;
			LenRd <= '0;
			LenCnt <= '0;
			RdCnt <= '0;
		end else begin
			if (Push) LenWr <= NextPtr(LenWr);
			if (Retire) LenRd <= NextPtr(LenRd);
			if (Push && !Retire) begin
				LenCnt <= LenCnt + 1'b1;
			end else if (Retire && !Push) begin
				LenCnt <= LenCnt - 1'b1;
			end
			if (Retire) begin
				RdCnt <= '0;   // Head fragment fully read
			end else if (Rd) begin
				RdCnt <= RdCnt + 1'b1;
			end
		end
	end

endmodule

//--- design/EvtBuildPkg.sv
/*
 Event builder shared definitions
 Word and length types, the fixed event markers and the limit
 on the number of data words in a single front-end fragment
*/
package EvtBuildPkg;

	// Every stream word, in and out, is 12 bits wide
	localparam int WordW = 12;
	typedef logic [WordW-1:0] WordT;

	// Time tag since start of run, sent as three words with the MSB word first
	localparam int TagW = 36;

	typedef logic [31:0] EvtNumT;   // Running event number

	// The two words that open every event so a receiver can find the start
	localparam WordT MarkerA = 12'hF04;
	localparam WordT MarkerB = 12'h354;

	// Code placed in the top two bits of the first event-number word
	localparam logic [1:0] EvtNumFlag = 2'b10;

	// Longest fragment a channel may deliver, set by the 5-bit count in the
	// channel header word
	localparam int MaxFragLen = 31;
	typedef logic [4:0] LenT;

endpackage
